/* mmu_pkg.sv */
package mmu_pkg;

    // Bus widths
    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;

    // Cache geometry, shared by both caches
    localparam int NUM_LANES        = 4;
    localparam int LANE_OFFSET_BITS = 4;
    localparam int LANE_BITS        = 8 << LANE_OFFSET_BITS;
    localparam int WORDS_PER_LANE   = LANE_BITS / WORD_BITS;

    // Byte address
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Store data word
    typedef logic [WORD_BITS-1:0] word_t;

    // Full lane, word 0 in the low bits
    typedef logic [LANE_BITS-1:0] lane_t;

    // Lane number within one cache
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    // Arbiter FSM
    typedef enum logic [2:0] {
        MMU_IDLE,
        DC_REQ,
        DC_WAIT,
        IC_REQ,
        IC_WAIT
    } mmu_state_e;

endpackage : mmu_pkg

/* mmu_lru.sv */
module mmu_lru (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               hit_i,
    input  mmu_pkg::lane_idx_t hit_lane_i,
    input  logic               fill_i,
    input  mmu_pkg::lane_idx_t fill_lane_i,
    output mmu_pkg::lane_idx_t victim_o
);

    import mmu_pkg::*;

    // One bit per lane pair (i < j), set while lane i is older than lane j
    localparam int AGE_BITS = NUM_LANES * (NUM_LANES - 1) / 2;

    logic [AGE_BITS-1:0] age_q;
    logic [AGE_BITS-1:0] age_d;

    function automatic int pair_idx(input int i, input int j);
        return i * (2 * NUM_LANES - i - 1) / 2 + (j - i - 1);
    endfunction

    // Make one lane newer than all the others
    function automatic logic [AGE_BITS-1:0] touch(input logic [AGE_BITS-1:0] age,
                                                  input lane_idx_t lane);
        logic [AGE_BITS-1:0] res;
        res = age;
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (j == int'(lane)) begin
                    res[pair_idx(i, j)] = 1'b1;
                end else if (i == int'(lane)) begin
                    res[pair_idx(i, j)] = 1'b0;
                end
            end
        end
        return res;
    endfunction

    function automatic logic is_oldest(input logic [AGE_BITS-1:0] age, input int lane);
        logic oldest;
        oldest = 1'b1;
        for (int m = 0; m < NUM_LANES; m++) begin
            if (m > lane && !age[pair_idx(lane, m)]) begin
                oldest = 1'b0;
            end else if (m < lane && age[pair_idx(m, lane)]) begin
                oldest = 1'b0;
            end
        end
        return oldest;
    endfunction

    // Hit goes in first, then the refill
    always_comb begin
        age_d = age_q;
        if (hit_i) begin
            age_d = touch(age_d, hit_lane_i);
        end
        if (fill_i) begin
            age_d = touch(age_d, fill_lane_i);
        end
    end

    // All ones gives the order 0, 1, 2, 3 from oldest to newest
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            age_q <= '1;
        end else begin
            age_q <= age_d;
        end
    end

    always_comb begin
        victim_o = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (is_oldest(age_q, l)) begin
                victim_o = lane_idx_t'(l);
            end
        end
    end

endmodule : mmu_lru

/* mmu_miss_arbiter.sv */
module mmu_miss_arbiter (
    input  logic               clk_i,
    input  logic               rst_i,
    // Data cache
    input  logic               dc_miss_i,
    input  mmu_pkg::addr_t     dc_addr_i,
    input  logic               dc_store_i,
    input  mmu_pkg::mem_size_e dc_store_size_i,
    input  mmu_pkg::word_t     dc_store_data_i,
    input  mmu_pkg::lane_idx_t dc_victim_i,
    output logic               dc_fill_o,
    output logic               dc_rdy_o,
    output mmu_pkg::lane_t     dc_data_o,
    output mmu_pkg::lane_idx_t dc_fill_lane_o,
    // Instruction cache
    input  logic               ic_miss_i,
    input  mmu_pkg::addr_t     ic_addr_i,
    input  mmu_pkg::lane_idx_t ic_victim_i,
    output logic               ic_fill_o,
    output logic               ic_rdy_o,
    output mmu_pkg::lane_t     ic_data_o,
    output mmu_pkg::lane_idx_t ic_fill_lane_o,
    // Main memory
    output logic               mem_rd_o,
    output mmu_pkg::addr_t     mem_addr_o,
    input  logic               mem_rdy_i,
    input  mmu_pkg::lane_t     mem_lane_i,
    output logic               mem_wr_o,
    output mmu_pkg::addr_t     mem_wr_addr_o,
    output mmu_pkg::mem_size_e mem_wr_size_o,
    output mmu_pkg::word_t     mem_wr_data_o
);

    import mmu_pkg::*;

    mmu_state_e state_q;
    mmu_state_e state_d;

    logic  dc_pending_q;
    logic  ic_pending_q;
    addr_t dc_line_q;
    addr_t ic_line_q;

    logic dc_done;
    logic ic_done;

    assign dc_done = (state_q == DC_WAIT) && mem_rdy_i;
    assign ic_done = (state_q == IC_WAIT) && mem_rdy_i;

    // Tracker touch lands on the same edge as rdy
    assign dc_fill_o = dc_done;
    assign ic_fill_o = ic_done;

    // Stores bypass straight to memory
    assign mem_wr_o      = dc_store_i;
    assign mem_wr_addr_o = dc_addr_i;
    assign mem_wr_size_o = dc_store_size_i;
    assign mem_wr_data_o = dc_store_data_i;

    // Lane-aligned miss addresses
    always_ff @(posedge clk_i) begin
        if (dc_miss_i) begin
            dc_line_q <= {dc_addr_i[ADDR_BITS-1:LANE_OFFSET_BITS], {LANE_OFFSET_BITS{1'b0}}};
        end
        if (ic_miss_i) begin
            ic_line_q <= {ic_addr_i[ADDR_BITS-1:LANE_OFFSET_BITS], {LANE_OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dc_pending_q <= 1'b0;
            ic_pending_q <= 1'b0;
        end else begin
            if (dc_miss_i) begin
                dc_pending_q <= 1'b1;
            end else if (dc_done) begin
                dc_pending_q <= 1'b0;
            end
            if (ic_miss_i) begin
                ic_pending_q <= 1'b1;
            end else if (ic_done) begin
                ic_pending_q <= 1'b0;
            end
        end
    end

    // Data side wins from idle; after a refill the other side goes next
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            MMU_IDLE: begin
                if (dc_pending_q) begin
                    state_d = DC_REQ;
                end else if (ic_pending_q) begin
                    state_d = IC_REQ;
                end
            end
            DC_REQ:  state_d = DC_WAIT;
            DC_WAIT: begin
                if (mem_rdy_i) begin
                    state_d = ic_pending_q ? IC_REQ : MMU_IDLE;
                end
            end
            IC_REQ:  state_d = IC_WAIT;
            IC_WAIT: begin
                if (mem_rdy_i) begin
                    state_d = dc_pending_q ? DC_REQ : MMU_IDLE;
                end
            end
            default: state_d = MMU_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= MMU_IDLE;
            mem_rd_o <= 1'b0;
            dc_rdy_o <= 1'b0;
            ic_rdy_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            mem_rd_o <= (state_q == DC_REQ) || (state_q == IC_REQ);
            dc_rdy_o <= dc_done;
            ic_rdy_o <= ic_done;
        end
    end

    // Refill payload, victim sampled in the mem_rdy cycle
    always_ff @(posedge clk_i) begin
        mem_addr_o <= (state_q == IC_REQ) ? ic_line_q : dc_line_q;
        if (dc_done) begin
            dc_data_o      <= mem_lane_i;
            dc_fill_lane_o <= dc_victim_i;
        end
        if (ic_done) begin
            ic_data_o      <= mem_lane_i;
            ic_fill_lane_o <= ic_victim_i;
        end
    end

endmodule : mmu_miss_arbiter

/* mmu_main_memory.sv */
module mmu_main_memory #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 256
) (
    input  logic               clk_i,
    input  logic               rst_i,
    // Lane read port
    input  logic               rd_i,
    input  mmu_pkg::addr_t     rd_addr_i,
    output logic               rdy_o,
    output mmu_pkg::lane_t     lane_o,
    // Sized write port
    input  logic               wr_i,
    input  mmu_pkg::addr_t     wr_addr_i,
    input  mmu_pkg::mem_size_e wr_size_i,
    input  mmu_pkg::word_t     wr_data_i
);

    import mmu_pkg::*;

    localparam int IDX_BITS   = $clog2(MEM_WORDS);
    localparam int BYTE_LANES = WORD_BITS / 8;

    logic [BYTE_LANES-1:0][7:0] mem_q [MEM_WORDS];

    logic [MEM_LATENCY-1:0] valid_q;
    addr_t                  addr_q [MEM_LATENCY];

    logic [IDX_BITS-1:0]        wr_idx;
    logic [BYTE_LANES-1:0]      wr_be;
    logic [BYTE_LANES-1:0][7:0] wr_bytes;
    logic [IDX_BITS-1:0]        rd_base;

    assign wr_idx = wr_addr_i[IDX_BITS+1:2];

    // Byte enables from size and low address bits
    always_comb begin
        unique case (wr_size_i)
            SIZE_BYTE: begin
                wr_be    = 4'b0001 << wr_addr_i[1:0];
                wr_bytes = {4{wr_data_i[7:0]}};
            end
            SIZE_HALF: begin
                wr_be    = 4'b0011 << wr_addr_i[1:0];
                wr_bytes = {2{wr_data_i[15:0]}};
            end
            SIZE_WORD: begin
                wr_be    = 4'b1111;
                wr_bytes = wr_data_i;
            end
            default: begin
                wr_be    = '0;
                wr_bytes = wr_data_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (wr_be[b]) begin
                    mem_q[wr_idx][b] <= wr_bytes[b];
                end
            end
        end
    end

    // Latency pipe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= rd_i;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q[0] <= rd_addr_i;
        for (int s = 1; s < MEM_LATENCY; s++) begin
            addr_q[s] <= addr_q[s-1];
        end
    end

    // Read late so writes during the wait are seen
    assign rd_base = {addr_q[MEM_LATENCY-1][IDX_BITS+1:LANE_OFFSET_BITS],
                      {(LANE_OFFSET_BITS-2){1'b0}}};
    assign rdy_o   = valid_q[MEM_LATENCY-1];

    always_comb begin
        for (int w = 0; w < WORDS_PER_LANE; w++) begin
            lane_o[w*WORD_BITS +: WORD_BITS] = mem_q[rd_base + IDX_BITS'(w)];
        end
    end

endmodule : mmu_main_memory

/* mmu_top.sv */
module mmu_top #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 256
) (
    input  logic               clk_i,
    input  logic               rst_i,
    // Data cache
    input  logic               dc_miss_i,
    input  mmu_pkg::addr_t     dc_addr_i,
    input  logic               dc_hit_i,
    input  mmu_pkg::lane_idx_t dc_hit_lane_i,
    input  logic               dc_store_i,
    input  mmu_pkg::mem_size_e dc_store_size_i,
    input  mmu_pkg::word_t     dc_store_data_i,
    output logic               dc_rdy_o,
    output mmu_pkg::lane_t     dc_data_o,
    output mmu_pkg::lane_idx_t dc_fill_lane_o,
    // Instruction cache
    input  logic               ic_miss_i,
    input  mmu_pkg::addr_t     ic_addr_i,
    input  logic               ic_hit_i,
    input  mmu_pkg::lane_idx_t ic_hit_lane_i,
    output logic               ic_rdy_o,
    output mmu_pkg::lane_t     ic_data_o,
    output mmu_pkg::lane_idx_t ic_fill_lane_o
);

    import mmu_pkg::*;

    lane_idx_t dc_victim;
    lane_idx_t ic_victim;
    logic      dc_fill;
    logic      ic_fill;

    logic      mem_rd;
    addr_t     mem_addr;
    logic      mem_rdy;
    lane_t     mem_lane;
    logic      mem_wr;
    addr_t     mem_wr_addr;
    mem_size_e mem_wr_size;
    word_t     mem_wr_data;

    mmu_miss_arbiter u_mmu_miss_arbiter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .dc_miss_i       (dc_miss_i),
        .dc_addr_i       (dc_addr_i),
        .dc_store_i      (dc_store_i),
        .dc_store_size_i (dc_store_size_i),
        .dc_store_data_i (dc_store_data_i),
        .dc_victim_i     (dc_victim),
        .dc_fill_o       (dc_fill),
        .dc_rdy_o        (dc_rdy_o),
        .dc_data_o       (dc_data_o),
        .dc_fill_lane_o  (dc_fill_lane_o),
        .ic_miss_i       (ic_miss_i),
        .ic_addr_i       (ic_addr_i),
        .ic_victim_i     (ic_victim),
        .ic_fill_o       (ic_fill),
        .ic_rdy_o        (ic_rdy_o),
        .ic_data_o       (ic_data_o),
        .ic_fill_lane_o  (ic_fill_lane_o),
        .mem_rd_o        (mem_rd),
        .mem_addr_o      (mem_addr),
        .mem_rdy_i       (mem_rdy),
        .mem_lane_i      (mem_lane),
        .mem_wr_o        (mem_wr),
        .mem_wr_addr_o   (mem_wr_addr),
        .mem_wr_size_o   (mem_wr_size),
        .mem_wr_data_o   (mem_wr_data)
    );

    // A refill always fills the tracker's own victim
    mmu_lru u_dc_lru (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hit_i       (dc_hit_i),
        .hit_lane_i  (dc_hit_lane_i),
        .fill_i      (dc_fill),
        .fill_lane_i (dc_victim),
        .victim_o    (dc_victim)
    );

    mmu_lru u_ic_lru (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hit_i       (ic_hit_i),
        .hit_lane_i  (ic_hit_lane_i),
        .fill_i      (ic_fill),
        .fill_lane_i (ic_victim),
        .victim_o    (ic_victim)
    );

    mmu_main_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_mmu_main_memory (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_i      (mem_rd),
        .rd_addr_i (mem_addr),
        .rdy_o     (mem_rdy),
        .lane_o    (mem_lane),
        .wr_i      (mem_wr),
        .wr_addr_i (mem_wr_addr),
        .wr_size_i (mem_wr_size),
        .wr_data_i (mem_wr_data)
    );

endmodule : mmu_top

/* mmu_chk.sv */
module mmu_chk (
    input logic clk_i,
    input logic rst_i,
    input logic dc_miss_i,
    input logic ic_miss_i,
    input logic dc_pending_i,
    input logic ic_pending_i,
    input logic mem_rd_i,
    input logic dc_rdy_i,
    input logic ic_rdy_i
);

    // Read requests are one-cycle strobes
    mem_rd_single: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_rd_i |=> !mem_rd_i)
        else $error("mem_rd_o was high for two cycles in a row");

    // One outstanding miss per cache
    dc_miss_alone: assert property (@(posedge clk_i) disable iff (rst_i)
        dc_miss_i |-> !dc_pending_i)
        else $error("data miss arrived while a data miss was pending");

    ic_miss_alone: assert property (@(posedge clk_i) disable iff (rst_i)
        ic_miss_i |-> !ic_pending_i)
        else $error("instruction miss arrived while an instruction miss was pending");

    rdy_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(dc_rdy_i && ic_rdy_i))
        else $error("dc_rdy_o and ic_rdy_o were high in the same cycle");

endmodule : mmu_chk

/* mmu_tb.sv */
module mmu_tb;

    import mmu_pkg::*;

    localparam int MEM_LATENCY = 3;
    localparam int MEM_WORDS   = 256;
    localparam int BYTE_BITS   = $clog2(MEM_WORDS * 4);

    logic      clk;
    logic      rst;
    logic      dc_miss;
    addr_t     dc_addr;
    logic      dc_hit;
    lane_idx_t dc_hit_lane;
    logic      dc_store;
    mem_size_e dc_store_size;
    word_t     dc_store_data;
    logic      dc_rdy;
    lane_t     dc_data;
    lane_idx_t dc_fill_lane;
    logic      ic_miss;
    addr_t     ic_addr;
    logic      ic_hit;
    lane_idx_t ic_hit_lane;
    logic      ic_rdy;
    lane_t     ic_data;
    lane_idx_t ic_fill_lane;

    // Byte image of main memory
    logic [7:0] model_mem [MEM_WORDS*4];
    // Recency lists per cache (0 data, 1 instruction) with the oldest first
    lane_idx_t  order [2][NUM_LANES];

    logic [31:0] lfsr_q = 32'h13722404;
    string       lines [$];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    mmu_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_mmu_top (
        .clk_i           (clk),
        .rst_i           (rst),
        .dc_miss_i       (dc_miss),
        .dc_addr_i       (dc_addr),
        .dc_hit_i        (dc_hit),
        .dc_hit_lane_i   (dc_hit_lane),
        .dc_store_i      (dc_store),
        .dc_store_size_i (dc_store_size),
        .dc_store_data_i (dc_store_data),
        .dc_rdy_o        (dc_rdy),
        .dc_data_o       (dc_data),
        .dc_fill_lane_o  (dc_fill_lane),
        .ic_miss_i       (ic_miss),
        .ic_addr_i       (ic_addr),
        .ic_hit_i        (ic_hit),
        .ic_hit_lane_i   (ic_hit_lane),
        .ic_rdy_o        (ic_rdy),
        .ic_data_o       (ic_data),
        .ic_fill_lane_o  (ic_fill_lane)
    );

    // Checker on u_mmu_top.u_mmu_miss_arbiter
    bind mmu_miss_arbiter mmu_chk u_mmu_chk (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dc_miss_i    (dc_miss_i),
        .ic_miss_i    (ic_miss_i),
        .dc_pending_i (dc_pending_q),
        .ic_pending_i (ic_pending_q),
        .mem_rd_i     (mem_rd_o),
        .dc_rdy_i     (dc_rdy_o),
        .ic_rdy_i     (ic_rdy_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            stop_failed();
        end
    end

    task automatic check_lane(input string what, input lane_t got, input lane_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_idx(input string what, input lane_idx_t got, input lane_idx_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s: got %0d cycles, expected %0d", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic reject_line(input string line);
        $display("Malformed line in mmu_golden.txt: %s", line);
        stop_failed();
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_q[0]};
            lfsr_q = next_lfsr(lfsr_q);
        end
        return w;
    endfunction

    // Byte k of the lane sits at bits k*8
    function automatic lane_t model_lane(input addr_t a);
        lane_t                l;
        logic [BYTE_BITS-1:0] base;
        base = {a[BYTE_BITS-1:LANE_OFFSET_BITS], {LANE_OFFSET_BITS{1'b0}}};
        for (int k = 0; k < 16; k++) begin
            l[k*8 +: 8] = model_mem[base + BYTE_BITS'(k)];
        end
        return l;
    endfunction

    task automatic make_newest(input int c, input lane_idx_t lane);
        int p;
        p = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (order[c][k] == lane) begin
                p = k;
            end
        end
        for (int k = p; k < NUM_LANES - 1; k++) begin
            order[c][k] = order[c][k+1];
        end
        order[c][NUM_LANES-1] = lane;
    endtask

    task automatic store_bytes(input addr_t addr, input mem_size_e size, input word_t data);
        logic [BYTE_BITS-1:0] a;
        a = addr[BYTE_BITS-1:0];
        @(negedge clk);
        dc_store      = 1'b1;
        dc_addr       = addr;
        dc_store_size = size;
        dc_store_data = data;
        @(negedge clk);
        dc_store = 1'b0;
        model_mem[a] = data[7:0];
        if (size != SIZE_BYTE) begin
            model_mem[a + BYTE_BITS'(1)] = data[15:8];
        end
        if (size == SIZE_WORD) begin
            model_mem[a + BYTE_BITS'(2)] = data[23:16];
            model_mem[a + BYTE_BITS'(3)] = data[31:24];
        end
    endtask

    task automatic touch_hit(input int c, input lane_idx_t lane);
        @(negedge clk);
        if (c == 0) begin
            dc_hit      = 1'b1;
            dc_hit_lane = lane;
        end else begin
            ic_hit      = 1'b1;
            ic_hit_lane = lane;
        end
        @(negedge clk);
        dc_hit = 1'b0;
        ic_hit = 1'b0;
        make_newest(c, lane);
    endtask

    task automatic refill(input logic do_dc, input logic do_ic,
                          input addr_t d_addr, input addr_t i_addr,
                          input lane_idx_t d_fill, input lane_idx_t i_fill,
                          input logic d_known, input logic i_known,
                          input lane_t d_lane, input lane_t i_lane);
        logic d_seen;
        logic i_seen;
        int   cycles;
        @(negedge clk);
        dc_miss = do_dc;
        ic_miss = do_ic;
        dc_addr = d_addr;
        ic_addr = i_addr;
        @(negedge clk);
        dc_miss = 1'b0;
        ic_miss = 1'b0;
        d_seen  = !do_dc;
        i_seen  = !do_ic;
        cycles  = 0;
        while (!(d_seen && i_seen)) begin
            if (dc_rdy && ic_rdy) begin
                $display("Both ready outputs were high in the same cycle");
                stop_failed();
            end
            if (dc_rdy) begin
                if (d_seen) begin
                    $display("Data cache ready without a pending data miss");
                    stop_failed();
                end
                // Pending, REQ state, request edge, then the memory latency
                if (!do_ic) begin
                    check_cycles("data miss latency", cycles, MEM_LATENCY + 3);
                end
                check_lane("data lane", dc_data, d_known ? d_lane : model_lane(d_addr));
                check_idx("data fill lane", dc_fill_lane, d_fill);
                check_idx("data fill vs recency list", dc_fill_lane, order[0][0]);
                make_newest(0, dc_fill_lane);
                d_seen = 1'b1;
            end
            if (ic_rdy) begin
                if (i_seen || !d_seen) begin
                    $display("Instruction cache ready out of turn");
                    stop_failed();
                end
                if (!do_dc) begin
                    check_cycles("instruction miss latency", cycles, MEM_LATENCY + 3);
                end
                check_lane("instr lane", ic_data, i_known ? i_lane : model_lane(i_addr));
                check_idx("instr fill lane", ic_fill_lane, i_fill);
                check_idx("instr fill vs recency list", ic_fill_lane, order[1][0]);
                make_newest(1, ic_fill_lane);
                i_seen = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        int    size;
        int    fill;
        int    fill2;
        addr_t addr;
        addr_t addr2;
        word_t data;
        lane_t exp_lane;
        logic  known;
        string line;
        string op;
        string field;

        rst           = 1'b1;
        dc_miss       = 1'b0;
        dc_addr       = '0;
        dc_hit        = 1'b0;
        dc_hit_lane   = '0;
        dc_store      = 1'b0;
        dc_store_size = SIZE_WORD;
        dc_store_data = '0;
        ic_miss       = 1'b0;
        ic_addr       = '0;
        ic_hit        = 1'b0;
        ic_hit_lane   = '0;
        for (int c = 0; c < 2; c++) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                order[c][k] = lane_idx_t'(k);
            end
        end

        fd = $fopen("mmu_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open mmu_golden.txt");
            stop_failed();
        end
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 20 * lines.size();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (lines[n]) begin
            line = lines[n];
            cnt  = $sscanf(line, "%s", op);
            if (cnt != 1) begin
                reject_line(line);
            end
            if (op == "store") begin
                cnt = $sscanf(line, "%s %h %d %s", op, addr, size, field);
                if (cnt != 4) begin
                    reject_line(line);
                end
                if (field == "r") begin
                    data = random_word();
                end else begin
                    cnt = $sscanf(field, "%h", data);
                    if (cnt != 1) begin
                        reject_line(line);
                    end
                end
                store_bytes(addr, mem_size_e'(size[1:0]), data);
            end else if (op == "dmiss" || op == "imiss") begin
                cnt = $sscanf(line, "%s %h %s %d", op, addr, field, fill);
                if (cnt != 4) begin
                    reject_line(line);
                end
                known = (field != "-");
                if (known) begin
                    cnt = $sscanf(field, "%h", exp_lane);
                    if (cnt != 1) begin
                        reject_line(line);
                    end
                end
                if (op == "dmiss") begin
                    refill(1'b1, 1'b0, addr, '0, fill[1:0], '0, known, 1'b0, exp_lane, '0);
                end else begin
                    refill(1'b0, 1'b1, '0, addr, '0, fill[1:0], 1'b0, known, '0, exp_lane);
                end
            end else if (op == "both") begin
                cnt = $sscanf(line, "%s %h %h %d %d", op, addr, addr2, fill, fill2);
                if (cnt != 5) begin
                    reject_line(line);
                end
                refill(1'b1, 1'b1, addr, addr2, fill[1:0], fill2[1:0],
                       1'b0, 1'b0, '0, '0);
            end else if (op == "dhit" || op == "ihit") begin
                cnt = $sscanf(line, "%s %d", op, fill);
                if (cnt != 2) begin
                    reject_line(line);
                end
                touch_hit((op == "dhit") ? 0 : 1, fill[1:0]);
            end else begin
                reject_line(line);
            end
        end

        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule : mmu_tb

/* mmu_golden.txt */
# store ADDR SIZE DATA: SIZE 0 byte, 1 half, 2 word; DATA r takes a word from the LFSR
# dmiss/imiss ADDR LANE FILL (LANE - uses the model); both DADDR IADDR DFILL IFILL; dhit/ihit LANE
store 100 2 11223344
store 104 2 55667788
store 108 2 99aabbcc
store 10c 2 ddeeff00
store 106 1 cafe
store 109 0 a5
store 10f 0 5a
dmiss 104 5aeeff0099aaa5cccafe778811223344 0
imiss 108 5aeeff0099aaa5cccafe778811223344 0
store 200 2 r
store 204 2 r
store 208 2 r
store 20c 2 r
dmiss 200 - 1
dmiss 208 - 2
dmiss 10c 5aeeff0099aaa5cccafe778811223344 3
dmiss 204 - 0
both 200 100 1 1
dhit 2
dhit 0
dmiss 100 - 3
ihit 3
ihit 2
imiss 204 - 0
store 20a 1 r
store 203 0 r
both 10c 204 1 1
dhit 3
dmiss 100 - 2
imiss 10c - 3

/* sources.f */
mmu_pkg.sv
mmu_lru.sv
mmu_miss_arbiter.sv
mmu_main_memory.sv
mmu_top.sv
mmu_chk.sv
mmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mmu_tb \
    -f sources.f --Mdir obj_dir -o mmu_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/mmu_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
